// ==== logic/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    localparam int addr_width = 16;  // byte address.
    localparam int data_width = 8;   // one byte per bus cycle.

    ////////////////////
    // wishbone classic
    ////////////////////

    // master to slave.
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [addr_width-1:0] adr;
        logic [data_width-1:0] dat;  // write data.
    } wb_req_t;

    // slave to master.
    typedef struct packed {
        logic                  ack;
        logic [data_width-1:0] dat;  // read data, valid with ack.
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== logic/mover_pkg.sv ====
`default_nettype none

package mover_pkg;

    localparam int len_width = 16;  // byte count.

    ////////////////////
    // move command
    ////////////////////

    // src and dst are byte addresses on the shared bus.
    typedef struct packed {
        logic [bus_pkg::addr_width-1:0] src;
        logic [bus_pkg::addr_width-1:0] dst;
        logic [len_width-1:0]           length;
    } move_cmd_t;

    // regions must not overlap and must not wrap past the top address.

endpackage

`default_nettype wire

// ==== logic/byte_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module byte_memory #(
    parameter int mem_words = 16384
) (
    input  wire logic             clk,
    input  wire bus_pkg::wb_req_t req,
    output bus_pkg::wb_rsp_t      rsp
);

    localparam int word_bits = $clog2(mem_words);

    logic [31:0] mem [mem_words];

    logic [word_bits-1:0] word_idx;
    logic [1:0]           lane;
    logic                 ack;
    logic [7:0]           rdata;

    assign word_idx = req.adr[word_bits+1:2];  // upper bits pick the word.
    assign lane     = req.adr[1:0];            // low bits pick the byte.

    ////////////////////
    // access
    ////////////////////

    always_ff @(posedge clk) begin
        ack <= 1'b0;
        if (req.cyc && req.stb && !ack) begin
            ack <= 1'b1;
            if (req.we) begin
                mem[word_idx][lane*8 +: 8] <= req.dat;  // only this lane.
            end else begin
                rdata <= mem[word_idx][lane*8 +: 8];
            end
        end
    end

    always_comb begin
        rsp.ack = ack;
        rsp.dat = rdata;
    end

    // a held request must not be answered twice.
    assert property (@(posedge clk) rsp.ack |=> !rsp.ack)
        else $error("byte_memory: ack high two cycles running");

endmodule

`default_nettype wire

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire bus_pkg::wb_req_t host_req,
    input  wire bus_pkg::wb_req_t reader_req,
    input  wire bus_pkg::wb_req_t writer_req,
    output bus_pkg::wb_rsp_t      host_rsp,
    output bus_pkg::wb_rsp_t      reader_rsp,
    output bus_pkg::wb_rsp_t      writer_rsp,
    output bus_pkg::wb_req_t      mem_req,
    input  wire bus_pkg::wb_rsp_t mem_rsp
);

    localparam int host_bit   = 0;
    localparam int reader_bit = 1;
    localparam int writer_bit = 2;

    logic [2:0] grant;        // one-hot, zero when idle.
    logic       writer_turn;  // reader goes first after reset.
    logic       granted_cyc;

    assign granted_cyc = (grant[host_bit]   && host_req.cyc)   ||
                         (grant[reader_bit] && reader_req.cyc) ||
                         (grant[writer_bit] && writer_req.cyc);

    ////////////////////
    // grant
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            grant       <= '0;
            writer_turn <= 1'b0;
        end else if (grant != '0) begin
            if (!granted_cyc) begin
                grant <= '0;  // master dropped cyc.
            end
        end else if (host_req.cyc) begin
            grant[host_bit] <= 1'b1;
        end else if (reader_req.cyc && (!writer_req.cyc || !writer_turn)) begin
            grant[reader_bit] <= 1'b1;
            writer_turn       <= 1'b1;
        end else if (writer_req.cyc) begin
            grant[writer_bit] <= 1'b1;
            writer_turn       <= 1'b0;
        end
    end

    ////////////////////
    // routing
    ////////////////////

    always_comb begin
        mem_req = '0;
        if (grant[host_bit]) begin
            mem_req = host_req;
        end else if (grant[reader_bit]) begin
            mem_req = reader_req;
        end else if (grant[writer_bit]) begin
            mem_req = writer_req;
        end
    end

    always_comb begin
        host_rsp       = mem_rsp;
        reader_rsp     = mem_rsp;
        writer_rsp     = mem_rsp;
        host_rsp.ack   = mem_rsp.ack && grant[host_bit];  // ack to the owner only.
        reader_rsp.ack = mem_rsp.ack && grant[reader_bit];
        writer_rsp.ack = mem_rsp.ack && grant[writer_bit];
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
        else $error("bus_arbiter: more than one grant active");

endmodule

`default_nettype wire

// ==== logic/block_reader.sv ====
`timescale 1ns/100ps
`default_nettype none

module block_reader #(
    parameter int fifo_depth = 8
) (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      start,
    input  wire mover_pkg::move_cmd_t      cmd,
    input  wire logic [$clog2(fifo_depth):0] level,
    output bus_pkg::wb_req_t               bus_req,
    input  wire bus_pkg::wb_rsp_t          bus_rsp,
    output logic                           push,
    output logic [7:0]                     push_data
);

    localparam int count_width = $clog2(fifo_depth) + 1;

    logic [bus_pkg::addr_width-1:0] rd_addr;
    logic [mover_pkg::len_width-1:0] remaining;
    logic                            req_cyc;
    logic [count_width:0]            pending;
    logic                            room;

    // bytes already in the FIFO plus the one on its way.
    assign pending = {1'b0, level} + (count_width+1)'(req_cyc);
    assign room    = pending < fifo_depth;

    ////////////////////
    // read requests
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            req_cyc   <= 1'b0;
            remaining <= '0;
        end else if (start) begin
            rd_addr   <= cmd.src;
            remaining <= cmd.length;
        end else if (req_cyc) begin
            if (bus_rsp.ack) begin
                req_cyc   <= 1'b0;
                rd_addr   <= rd_addr + 1'b1;
                remaining <= remaining - 1'b1;
            end
        end else if (remaining != '0 && room) begin
            req_cyc <= 1'b1;  // wait for space first.
        end
    end

    always_comb begin
        bus_req     = '0;
        bus_req.cyc = req_cyc;
        bus_req.stb = req_cyc;
        bus_req.we  = 1'b0;
        bus_req.adr = rd_addr;
    end

    // the byte goes to the FIFO on the ack edge.
    assign push      = req_cyc && bus_rsp.ack;
    assign push_data = bus_rsp.dat;

    assert property (@(posedge clk) disable iff (reset)
        bus_req.stb && !bus_rsp.ack |=> bus_req.stb && $stable(bus_req.adr))
        else $error("block_reader: request changed before ack");

endmodule

`default_nettype wire

// ==== logic/byte_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module byte_fifo #(
    parameter int fifo_depth = 8
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  push,
    input  wire logic [7:0]            push_data,
    input  wire logic                  pop,
    output logic [7:0]                 head,
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(fifo_depth):0] level
);

    localparam int ptr_width = $clog2(fifo_depth);

    logic [7:0]           buffer [fifo_depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width:0]   count;
    logic                 do_push;
    logic                 do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (do_push) begin
            buffer[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two.
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign head  = buffer[rd_ptr];
    assign empty = count == '0;
    assign full  = count == fifo_depth;
    assign level = count;

    assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("byte_fifo: push while full");
    assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("byte_fifo: pop while empty");

endmodule

`default_nettype wire

// ==== logic/block_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module block_writer (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 start,
    input  wire mover_pkg::move_cmd_t cmd,
    input  wire logic [7:0]           head,
    input  wire logic                 empty,
    output logic                      pop,
    output bus_pkg::wb_req_t          bus_req,
    input  wire bus_pkg::wb_rsp_t     bus_rsp,
    output logic                      busy,
    output logic                      done
);

    logic [bus_pkg::addr_width-1:0]  wr_addr;
    logic [mover_pkg::len_width-1:0] remaining;
    logic                            req_cyc;

    ////////////////////
    // command and writes
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            req_cyc   <= 1'b0;
            remaining <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy      <= 1'b1;
                wr_addr   <= cmd.dst;
                remaining <= cmd.length;
            end else if (busy) begin
                if (req_cyc) begin
                    if (bus_rsp.ack) begin
                        req_cyc   <= 1'b0;
                        wr_addr   <= wr_addr + 1'b1;
                        remaining <= remaining - 1'b1;
                    end
                end else if (remaining == '0) begin
                    busy <= 1'b0;  // last byte is stored.
                    done <= 1'b1;
                end else if (!empty) begin
                    req_cyc <= 1'b1;
                end
            end
        end
    end

    // head holds still until popped.
    always_comb begin
        bus_req     = '0;
        bus_req.cyc = req_cyc;
        bus_req.stb = req_cyc;
        bus_req.we  = 1'b1;
        bus_req.adr = wr_addr;
        bus_req.dat = head;
    end

    assign pop = req_cyc && bus_rsp.ack;

    assert property (@(posedge clk) disable iff (reset) done |-> $past(busy))
        else $error("block_writer: done without a move in progress");

endmodule

`default_nettype wire

// ==== logic/block_mover.sv ====
`timescale 1ns/100ps
`default_nettype none

module block_mover #(
    parameter int mem_words  = 16384,
    parameter int fifo_depth = 8
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire bus_pkg::wb_req_t     host_req,
    output bus_pkg::wb_rsp_t          host_rsp,
    input  wire logic                 start,
    input  wire mover_pkg::move_cmd_t cmd,
    output logic                      busy,
    output logic                      done
);

    localparam int count_width = $clog2(fifo_depth) + 1;

    bus_pkg::wb_req_t reader_req;
    bus_pkg::wb_rsp_t reader_rsp;
    bus_pkg::wb_req_t writer_req;
    bus_pkg::wb_rsp_t writer_rsp;
    bus_pkg::wb_req_t mem_req;
    bus_pkg::wb_rsp_t mem_rsp;

    logic                   accept;
    logic                   push;
    logic [7:0]             push_data;
    logic                   pop;
    logic [7:0]             head;
    logic                   empty;
    logic [count_width-1:0] level;

    assign accept = start && !busy;  // a start while busy is dropped.

    ////////////////////
    // shared memory
    ////////////////////

    bus_arbiter bus_arbiter_inst (
        .clk        (clk),
        .reset      (reset),
        .host_req   (host_req),
        .reader_req (reader_req),
        .writer_req (writer_req),
        .host_rsp   (host_rsp),
        .reader_rsp (reader_rsp),
        .writer_rsp (writer_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    byte_memory #(.mem_words(mem_words)) byte_memory_inst (
        .clk (clk),
        .req (mem_req),
        .rsp (mem_rsp)
    );

    ////////////////////
    // data path
    ////////////////////

    block_reader #(.fifo_depth(fifo_depth)) block_reader_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (accept),
        .cmd       (cmd),
        .level     (level),
        .bus_req   (reader_req),
        .bus_rsp   (reader_rsp),
        .push      (push),
        .push_data (push_data)
    );

    byte_fifo #(.fifo_depth(fifo_depth)) byte_fifo_inst (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .full      (),
        .level     (level)
    );

    block_writer block_writer_inst (
        .clk     (clk),
        .reset   (reset),
        .start   (accept),
        .cmd     (cmd),
        .head    (head),
        .empty   (empty),
        .pop     (pop),
        .bus_req (writer_req),
        .bus_rsp (writer_rsp),
        .busy    (busy),
        .done    (done)
    );

endmodule

`default_nettype wire

// ==== tests/block_mover_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module block_mover_tb;

    localparam int mem_words  = 16384;
    localparam int fifo_depth = 8;
    localparam int ack_limit  = 200;   // cycles per host access.
    localparam int done_limit = 4000;  // cycles per move.

    logic                 clk;
    logic                 reset;
    bus_pkg::wb_req_t     host_req;
    bus_pkg::wb_rsp_t     host_rsp;
    logic                 start;
    mover_pkg::move_cmd_t cmd;
    logic                 busy;
    logic                 done;

    logic [7:0] model [65536];  // expected byte of every address.
    integer     seed;
    int         done_count;
    int         test_errors;
    int         tests_passed;
    int         tests_failed;
    string      test_name;

    block_mover #(.mem_words(mem_words), .fifo_depth(fifo_depth)) block_mover_inst (
        .clk      (clk),
        .reset    (reset),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .start    (start),
        .cmd      (cmd),
        .busy     (busy),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        if (done) begin
            done_count = done_count + 1;
        end
    end

    ////////////////////
    // bookkeeping
    ////////////////////

    task automatic open_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic close_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_errors);
        end
    endtask

    task automatic compare_byte(input logic [15:0] addr, input logic [7:0] expected,
                                input logic [7:0] actual);
        assert (actual === expected) else begin
            $display("Error: %s at 0x%h expected 0x%h actual 0x%h",
                     test_name, addr, expected, actual);
            test_errors++;
        end
    endtask

    ////////////////////
    // host port
    ////////////////////

    task automatic write_byte(input logic [15:0] addr, input logic [7:0] data);
        bus_pkg::wb_req_t req;
        int               waited;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = 1'b1;
        req.adr = addr;
        req.dat = data;
        @(posedge clk);
        host_req <= req;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!host_rsp.ack && waited < ack_limit);
        if (!host_rsp.ack) begin
            $display("host write to 0x%h got no ack within %0d cycles", addr, ack_limit);
            test_errors++;
        end else begin
            model[addr] = data;
        end
        @(posedge clk);
        host_req <= '0;  // drop cyc after ack.
    endtask

    task automatic read_byte(input logic [15:0] addr, output logic [7:0] data);
        bus_pkg::wb_req_t req;
        int               waited;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.adr = addr;
        data    = 'x;
        @(posedge clk);
        host_req <= req;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!host_rsp.ack && waited < ack_limit);
        if (!host_rsp.ack) begin
            $display("host read from 0x%h got no ack within %0d cycles", addr, ack_limit);
            test_errors++;
        end else begin
            data = host_rsp.dat;
        end
        @(posedge clk);
        host_req <= '0;
    endtask

    task automatic preload(input logic [15:0] base, input int count);
        for (int i = 0; i < count; i++) begin
            write_byte(base + 16'(i), 8'($random(seed)));
        end
    endtask

    task automatic check_region(input logic [15:0] base, input int count);
        logic [7:0] data;
        for (int i = 0; i < count; i++) begin
            read_byte(base + 16'(i), data);
            compare_byte(base + 16'(i), model[base + 16'(i)], data);
        end
    endtask

    ////////////////////
    // move commands
    ////////////////////

    // destination takes the source byte at the same offset.
    task automatic copy_in_model(input logic [15:0] src, input logic [15:0] dst,
                                 input int length);
        for (int i = 0; i < length; i++) begin
            model[dst + 16'(i)] = model[src + 16'(i)];
        end
    endtask

    task automatic launch_move(input logic [15:0] src, input logic [15:0] dst,
                               input logic [15:0] length);
        mover_pkg::move_cmd_t c;
        c.src    = src;
        c.dst    = dst;
        c.length = length;
        @(posedge clk);
        start <= 1'b1;
        cmd   <= c;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic await_done();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!done && waited < done_limit);
        if (!done) begin
            $display("move in %s did not signal done within %0d cycles", test_name, done_limit);
            test_errors++;
        end
    endtask

    task automatic expect_busy();
        @(negedge clk);
        assert (busy === 1'b1) else begin
            $display("Error: %s busy expected 1 actual %b", test_name, busy);
            test_errors++;
        end
    endtask

    task automatic settle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        logic [7:0] data;
        int         done_before;
        seed         = 80227;
        reset        = 1'b1;
        host_req     = '0;
        start        = 1'b0;
        cmd          = '0;
        done_count   = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
        end
        reset <= 1'b0;

        open_test("byte_lanes");
        preload(16'h00ff, 6);  // all four lanes of one word and both neighbors.
        check_region(16'h00ff, 6);
        close_test();

        open_test("block_copy");
        preload(16'h1000, 40);
        preload(16'h1fff, 42);  // destination plus one guard byte each side.
        launch_move(16'h1000, 16'h2000, 16'd40);
        await_done();
        copy_in_model(16'h1000, 16'h2000, 40);
        check_region(16'h2000, 40);
        close_test();

        open_test("region_bounds");
        check_region(16'h1fff, 1);
        check_region(16'h2028, 1);
        close_test();

        open_test("zero_length");
        preload(16'h3000, 4);
        launch_move(16'h1000, 16'h3000, 16'd0);
        expect_busy();
        await_done();
        check_region(16'h3000, 4);
        close_test();

        open_test("host_during_move");
        preload(16'h4000, 1);
        preload(16'h4fff, 42);
        launch_move(16'h1000, 16'h5000, 16'd40);
        expect_busy();
        read_byte(16'h4000, data);
        compare_byte(16'h4000, model[16'h4000], data);
        await_done();
        copy_in_model(16'h1000, 16'h5000, 40);
        check_region(16'h4fff, 42);
        close_test();

        open_test("start_while_busy");
        preload(16'h5fff, 42);
        preload(16'h7000, 16);
        done_before = done_count;
        launch_move(16'h1000, 16'h6000, 16'd40);
        expect_busy();
        launch_move(16'h1000, 16'h7000, 16'd16);  // dropped, mover is busy.
        await_done();
        settle(20);
        assert (done_count - done_before == 1) else begin
            $display("Error: %s done pulses expected 1 actual %0d",
                     test_name, done_count - done_before);
            test_errors++;
        end
        copy_in_model(16'h1000, 16'h6000, 40);
        check_region(16'h5fff, 42);
        check_region(16'h7000, 16);
        close_test();

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
logic/bus_pkg.sv
logic/mover_pkg.sv
logic/byte_memory.sv
logic/bus_arbiter.sv
logic/block_reader.sv
logic/byte_fifo.sv
logic/block_writer.sv
logic/block_mover.sv
tests/block_mover_tb.sv
